/* ub_pkg.sv */
/*
 * Unaligned ICB bridge shared definitions
 * Bus widths, vector types and the controller state encoding
 */
package ub_pkg;

  // ==========================================================================
  // Bus geometry
  // ==========================================================================
  // Data word width
  localparam int BUS_W   = 32;
  // Byte lanes per word
  localparam int BYTES_W = BUS_W / 8;
  // Burst length field, beats minus one
  localparam int LEN_W   = 4;
  // Byte address width
  localparam int ADDR_W  = 32;

  // ==========================================================================
  // Vector types
  // ==========================================================================
  typedef logic [ADDR_W-1:0]          addr_t;
  typedef logic [BUS_W-1:0]           word_t;
  typedef logic [BYTES_W-1:0]         mask_t;
  typedef logic [LEN_W-1:0]           len_t;
  // Byte offset of an address inside its word
  typedef logic [$clog2(BYTES_W)-1:0] ofs_t;
  // Aligned word count, up to 17 for a 16 beat unaligned burst
  typedef logic [LEN_W:0]             wcnt_t;

  // Controller sequencing states
  typedef enum logic [2:0] {
    IDLE    = 3'd0,  // Waiting for an upstream command
    WR_WORD = 3'd1,  // Aligned write word pending or in issue
    WR_WAIT = 3'd2,  // Waiting for downstream write response
    RD_WORD = 3'd3,  // Read word issue or final beat drain
    RD_WAIT = 3'd4,  // Waiting for downstream read data
    WR_RSP  = 3'd5   // Single upstream write response
  } ctl_state_t;

endpackage

/* ub_ctl_if.sv */
/*
 * Control bundle between the command controller and the data paths
 * Carries command start, offset and per-word handshakes
 */
interface ub_ctl_if import ub_pkg::*; ();

  // Driven by the controller
  // Byte offset of the current command
  ofs_t  ofs;
  // One cycle pulse at upstream command accept
  logic  start;
  // Current write word consumed so the next one can be formed
  logic  word_req;
  // Downstream read word accepted this cycle
  logic  rd_word_valid;
  // Next word to be issued is the final one
  logic  last_word;

  // Driven by the write data path
  logic  word_rdy;
  word_t word;
  mask_t mask;

  // Driven by the read data path
  // Read beat handed to upstream this cycle
  logic  beat_taken;

  modport ctrl (
    output ofs, start, word_req, rd_word_valid, last_word,
    input  word_rdy, word, mask, beat_taken
  );

  modport dpath (
    input  ofs, start, word_req, rd_word_valid, last_word,
    output word_rdy, word, mask, beat_taken
  );

endinterface

/* ub_cmd_ctrl.sv */
/*
 * Command controller of the unaligned bridge
 * Accepts one upstream command and walks its aligned downstream words,
 * one access in flight at a time
 */
module ub_cmd_ctrl import ub_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  // Upstream command channel
  input  logic   sa_icb_cmd_valid,
  input  addr_t  sa_icb_cmd_addr,
  input  logic   sa_icb_cmd_read,
  input  len_t   sa_icb_cmd_len,
  output logic   sa_icb_cmd_ready,
  // Downstream command channel
  output logic   m_icb_cmd_valid,
  output addr_t  m_icb_cmd_addr,
  output logic   m_icb_cmd_read,
  input  logic   m_icb_cmd_ready,
  // Downstream response channel
  input  logic   m_icb_rsp_valid,
  output logic   m_icb_rsp_ready,
  // Upstream write response strobe
  input  logic   sa_icb_rsp_ready,
  output logic   wr_rsp_valid,
  ub_ctl_if.ctrl ctl
);

  ctl_state_t state;
  ctl_state_t nxt_state;
  logic       cmd_rdy_q;
  logic       cmd_vld_q;
  logic       read_q;
  ofs_t       ofs_q;
  addr_t      addr_q;
  wcnt_t      words_left_q;
  logic       beat_pend_q;
  logic       rd_first_q;
  logic       cmd_acc;
  logic       m_cmd_hs;
  logic       issue;
  ofs_t       cmd_ofs;

  assign cmd_acc  = sa_icb_cmd_valid && cmd_rdy_q;
  assign m_cmd_hs = cmd_vld_q && m_icb_cmd_ready;
  assign cmd_ofs  = ofs_t'(sa_icb_cmd_addr);

  // Raise cmd valid one cycle after the word or the read slot is there
  assign issue = !cmd_vld_q &&
                 (((state == WR_WORD) && ctl.word_rdy) ||
                  ((state == RD_WORD) && (words_left_q != '0)));

  // ==========================================================================
  // Sequencing FSM
  // ==========================================================================
  always_comb begin
    nxt_state = state;
    case (state)
      IDLE: begin
        if (cmd_acc) begin
          nxt_state = sa_icb_cmd_read ? RD_WORD : WR_WORD;
        end
      end
      WR_WORD: begin
        if (m_cmd_hs) begin
          nxt_state = WR_WAIT;
        end
      end
      WR_WAIT: begin
        // Counter already reflects the word in flight
        if (m_icb_rsp_valid) begin
          nxt_state = (words_left_q == '0) ? WR_RSP : WR_WORD;
        end
      end
      WR_RSP: begin
        if (sa_icb_rsp_ready) begin
          nxt_state = IDLE;
        end
      end
      RD_WORD: begin
        if (m_cmd_hs) begin
          nxt_state = RD_WAIT;
        end else if ((words_left_q == '0) && !beat_pend_q) begin
          // Last beat has left upstream
          nxt_state = IDLE;
        end
      end
      RD_WAIT: begin
        if (m_icb_rsp_valid && !beat_pend_q) begin
          nxt_state = RD_WORD;
        end
      end
      default: nxt_state = IDLE;
    endcase
  end

  // Control state
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= IDLE;
      cmd_rdy_q    <= 1'b0;
      cmd_vld_q    <= 1'b0;
      read_q       <= 1'b0;
      ofs_q        <= '0;
      words_left_q <= '0;
      beat_pend_q  <= 1'b0;
      rd_first_q   <= 1'b0;
    end else begin
      state     <= nxt_state;
      // Ready mirrors IDLE from the first cycle out of reset
      cmd_rdy_q <= (nxt_state == IDLE);
      if (m_cmd_hs) begin
        cmd_vld_q <= 1'b0;
      end else if (issue) begin
        cmd_vld_q <= 1'b1;
      end
      if (cmd_acc) begin
        read_q       <= sa_icb_cmd_read;
        ofs_q        <= cmd_ofs;
        // len+1 words, plus one when the burst straddles a word edge
        words_left_q <= wcnt_t'(sa_icb_cmd_len) + wcnt_t'(1) + wcnt_t'(cmd_ofs != '0);
      end else if (m_cmd_hs) begin
        words_left_q <= words_left_q - wcnt_t'(1);
      end
      if (cmd_acc) begin
        rd_first_q <= 1'b1;
      end else if (ctl.rd_word_valid) begin
        rd_first_q <= 1'b0;
      end
      // Tracks the read merge output register
      if (ctl.rd_word_valid && !(rd_first_q && (ofs_q != '0))) begin
        beat_pend_q <= 1'b1;
      end else if (ctl.beat_taken) begin
        beat_pend_q <= 1'b0;
      end
    end
  end

  // Aligned word address
  always_ff @(posedge clk) begin
    if (cmd_acc) begin
      addr_q <= sa_icb_cmd_addr & ~addr_t'(BYTES_W - 1);
    end else if (m_cmd_hs) begin
      addr_q <= addr_q + addr_t'(BYTES_W);
    end
  end

  assign sa_icb_cmd_ready  = cmd_rdy_q;
  assign m_icb_cmd_valid   = cmd_vld_q;
  assign m_icb_cmd_addr    = addr_q;
  assign m_icb_cmd_read    = read_q;
  // Read data stalls while the previous beat is still upstream
  assign m_icb_rsp_ready   = (state == WR_WAIT) || ((state == RD_WAIT) && !beat_pend_q);
  assign wr_rsp_valid      = (state == WR_RSP);

  assign ctl.ofs           = ofs_q;
  assign ctl.start         = cmd_acc;
  assign ctl.word_req      = m_cmd_hs && !read_q;
  assign ctl.rd_word_valid = (state == RD_WAIT) && m_icb_rsp_valid && !beat_pend_q;
  assign ctl.last_word     = (words_left_q == wcnt_t'(1));

  // ==========================================================================
  // Protocol checks
  // ==========================================================================
  a_m_cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_icb_cmd_valid && !m_icb_cmd_ready |=>
      m_icb_cmd_valid && $stable(m_icb_cmd_addr) && $stable(m_icb_cmd_read))
    else $error("Downstream command dropped or changed before accept");

  a_rdy_idle: assert property (@(posedge clk) disable iff (!rst_n)
    sa_icb_cmd_ready |-> (state == IDLE))
    else $error("Upstream command ready outside IDLE");

endmodule

/* ub_wr_align.sv */
/*
 * Write data path of the unaligned bridge
 * Rotates upstream beats by the byte offset and merges them with a carry
 * register into aligned words and byte masks
 */
module ub_wr_align import ub_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  // Upstream write data channel
  input  logic    sa_icb_w_valid,
  input  word_t   sa_icb_cmd_wdata,
  input  mask_t   sa_icb_cmd_wmask,
  output logic    sa_icb_w_ready,
  ub_ctl_if.dpath ctl
);

  logic                 active_q;
  logic                 word_rdy_q;
  mask_t                carry_mask_q;
  word_t                carry_data_q;
  word_t                word_q;
  mask_t                mask_q;
  logic                 ofs_nz;
  logic                 tail;
  logic                 w_hs;
  logic                 form;
  logic [2*BUS_W-1:0]   data_dbl;
  logic [2*BYTES_W-1:0] mask_dbl;
  word_t                rot_data;
  mask_t                rot_mask;
  word_t                src_data;
  mask_t                src_mask;
  mask_t                low_lanes;
  word_t                new_word;
  mask_t                new_mask;

  assign ofs_nz = (ctl.ofs != '0);
  // Final word of an unaligned write is built from the carry alone
  assign tail = active_q && !word_rdy_q && ctl.last_word && ofs_nz;
  assign sa_icb_w_ready = active_q && !word_rdy_q && !(ctl.last_word && ofs_nz);
  assign w_hs = sa_icb_w_valid && sa_icb_w_ready;
  assign form = w_hs || tail;

  // ==========================================================================
  // Byte rotation and merge
  // ==========================================================================
  always_comb begin
    // Rotate left by offset bytes
    data_dbl  = {sa_icb_cmd_wdata, sa_icb_cmd_wdata} << (8 * ctl.ofs);
    mask_dbl  = {sa_icb_cmd_wmask, sa_icb_cmd_wmask} << ctl.ofs;
    rot_data  = data_dbl[2*BUS_W-1:BUS_W];
    rot_mask  = mask_dbl[2*BYTES_W-1:BYTES_W];
    // No new beat in the tail word
    src_data  = w_hs ? rot_data : '0;
    src_mask  = w_hs ? rot_mask : '0;
    // Lanes below the offset come from the previous beat
    low_lanes = mask_t'((1 << ctl.ofs) - 1);
    new_word  = '0;
    new_mask  = '0;
    for (int l = 0; l < BYTES_W; l++) begin
      if (low_lanes[l]) begin
        new_word[8*l +: 8] = carry_data_q[8*l +: 8];
        new_mask[l]        = carry_mask_q[l];
      end else begin
        new_word[8*l +: 8] = src_data[8*l +: 8];
        new_mask[l]        = src_mask[l];
      end
    end
  end

  // Burst tracking and carry mask
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      word_rdy_q   <= 1'b0;
      carry_mask_q <= '0;
    end else if (ctl.start) begin
      active_q     <= 1'b1;
      word_rdy_q   <= 1'b0;
      // First word has nothing below the offset
      carry_mask_q <= '0;
    end else begin
      if (form) begin
        word_rdy_q <= 1'b1;
      end else if (ctl.word_req) begin
        word_rdy_q <= 1'b0;
      end
      if (ctl.word_req && ctl.last_word) begin
        active_q <= 1'b0;
      end
      if (w_hs) begin
        carry_mask_q <= rot_mask;
      end
    end
  end

  // Carry bytes and the presented word
  always_ff @(posedge clk) begin
    if (w_hs) begin
      carry_data_q <= rot_data;
    end
    if (form) begin
      word_q <= new_word;
      mask_q <= new_mask;
    end
  end

  assign ctl.word_rdy = word_rdy_q;
  assign ctl.word     = word_q;
  assign ctl.mask     = mask_q;

  // Upstream master keeps the beat until it is taken
  a_w_hold: assert property (@(posedge clk) disable iff (!rst_n)
    sa_icb_w_valid && !sa_icb_w_ready |=>
      sa_icb_w_valid && $stable(sa_icb_cmd_wdata) && $stable(sa_icb_cmd_wmask))
    else $error("Upstream write beat dropped or changed before accept");

endmodule

/* ub_rd_merge.sv */
/*
 * Read data path of the unaligned bridge
 * Joins consecutive aligned read words into unaligned upstream beats
 * and sends the single write response
 */
module ub_rd_merge import ub_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  // Downstream read data
  input  word_t   m_icb_rsp_rdata,
  // Write response strobe from the controller
  input  logic    wr_rsp_valid,
  // Upstream response channel
  output logic    sa_icb_rsp_valid,
  output word_t   sa_icb_rsp_rdata,
  input  logic    sa_icb_rsp_ready,
  ub_ctl_if.dpath ctl
);

  logic               first_q;
  logic               beat_vld_q;
  word_t              prev_q;
  word_t              beat_q;
  logic               produce;
  logic [2*BUS_W-1:0] pair;
  word_t              merged;

  // ==========================================================================
  // Beat assembly
  // ==========================================================================
  // First word of an unaligned read only primes the holding register
  assign produce = ctl.rd_word_valid && !(first_q && (ctl.ofs != '0));

  // Upper bytes of the held word then lower bytes of the new one
  assign pair   = {m_icb_rsp_rdata, prev_q} >> (8 * ctl.ofs);
  // Aligned reads pass straight through
  assign merged = (ctl.ofs == '0) ? m_icb_rsp_rdata : pair[BUS_W-1:0];

  // Beat valid and first word flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_q    <= 1'b0;
      beat_vld_q <= 1'b0;
    end else begin
      if (ctl.start) begin
        first_q <= 1'b1;
      end else if (ctl.rd_word_valid) begin
        first_q <= 1'b0;
      end
      // Controller only returns a word once the register is empty
      if (produce) begin
        beat_vld_q <= 1'b1;
      end else if (ctl.beat_taken) begin
        beat_vld_q <= 1'b0;
      end
    end
  end

  // Held word and output beat
  always_ff @(posedge clk) begin
    if (ctl.rd_word_valid) begin
      prev_q <= m_icb_rsp_rdata;
    end
    if (produce) begin
      beat_q <= merged;
    end
  end

  // ==========================================================================
  // Upstream response
  // ==========================================================================
  // Write response never overlaps a pending read beat
  assign sa_icb_rsp_valid = beat_vld_q || wr_rsp_valid;
  // Write response carries zero data
  assign sa_icb_rsp_rdata = beat_vld_q ? beat_q : '0;
  assign ctl.beat_taken   = beat_vld_q && sa_icb_rsp_ready;

endmodule

/* icb_unalign_bridge.sv */
/*
 * Unaligned ICB bridge top level
 * Splits unaligned upstream bursts into aligned downstream word accesses
 */
module icb_unalign_bridge import ub_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // Upstream command channel
  input  logic  sa_icb_cmd_valid,
  output logic  sa_icb_cmd_ready,
  input  addr_t sa_icb_cmd_addr,
  input  logic  sa_icb_cmd_read,
  input  len_t  sa_icb_cmd_len,
  // Upstream write data channel
  input  logic  sa_icb_w_valid,
  output logic  sa_icb_w_ready,
  input  word_t sa_icb_cmd_wdata,
  input  mask_t sa_icb_cmd_wmask,
  // Upstream response channel
  output logic  sa_icb_rsp_valid,
  input  logic  sa_icb_rsp_ready,
  output word_t sa_icb_rsp_rdata,
  // Downstream command channel
  output logic  m_icb_cmd_valid,
  input  logic  m_icb_cmd_ready,
  output addr_t m_icb_cmd_addr,
  output logic  m_icb_cmd_read,
  output word_t m_icb_cmd_wdata,
  output mask_t m_icb_cmd_wmask,
  // Downstream response channel
  input  logic  m_icb_rsp_valid,
  output logic  m_icb_rsp_ready,
  input  word_t m_icb_rsp_rdata
);

  logic wr_rsp_valid;

  ub_ctl_if ctl_if ();

  // Command sequencing
  ub_cmd_ctrl u_cmd_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .sa_icb_cmd_valid (sa_icb_cmd_valid),
    .sa_icb_cmd_addr  (sa_icb_cmd_addr),
    .sa_icb_cmd_read  (sa_icb_cmd_read),
    .sa_icb_cmd_len   (sa_icb_cmd_len),
    .sa_icb_cmd_ready (sa_icb_cmd_ready),
    .m_icb_cmd_valid  (m_icb_cmd_valid),
    .m_icb_cmd_addr   (m_icb_cmd_addr),
    .m_icb_cmd_read   (m_icb_cmd_read),
    .m_icb_cmd_ready  (m_icb_cmd_ready),
    .m_icb_rsp_valid  (m_icb_rsp_valid),
    .m_icb_rsp_ready  (m_icb_rsp_ready),
    .sa_icb_rsp_ready (sa_icb_rsp_ready),
    .wr_rsp_valid     (wr_rsp_valid),
    .ctl              (ctl_if.ctrl)
  );

  // Write beats into aligned words
  ub_wr_align u_wr_align (
    .clk              (clk),
    .rst_n            (rst_n),
    .sa_icb_w_valid   (sa_icb_w_valid),
    .sa_icb_cmd_wdata (sa_icb_cmd_wdata),
    .sa_icb_cmd_wmask (sa_icb_cmd_wmask),
    .sa_icb_w_ready   (sa_icb_w_ready),
    .ctl              (ctl_if.dpath)
  );

  // Read words into unaligned beats
  ub_rd_merge u_rd_merge (
    .clk              (clk),
    .rst_n            (rst_n),
    .m_icb_rsp_rdata  (m_icb_rsp_rdata),
    .wr_rsp_valid     (wr_rsp_valid),
    .sa_icb_rsp_valid (sa_icb_rsp_valid),
    .sa_icb_rsp_rdata (sa_icb_rsp_rdata),
    .sa_icb_rsp_ready (sa_icb_rsp_ready),
    .ctl              (ctl_if.dpath)
  );

  // Downstream write payload straight from the aligned word register
  assign m_icb_cmd_wdata = ctl_if.word;
  assign m_icb_cmd_wmask = ctl_if.mask;

endmodule

/* tb_word_mem.sv */
/*
 * Downstream word memory responder for the bridge testbench
 * Byte addressed store with random command stalls and response delays
 */
module tb_word_mem import ub_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  // Downstream command channel
  input  logic  m_icb_cmd_valid,
  output logic  m_icb_cmd_ready,
  input  addr_t m_icb_cmd_addr,
  input  logic  m_icb_cmd_read,
  input  word_t m_icb_cmd_wdata,
  input  mask_t m_icb_cmd_wmask,
  // Downstream response channel
  output logic  m_icb_rsp_valid,
  input  logic  m_icb_rsp_ready,
  output word_t m_icb_rsp_rdata
);
  timeunit 1ns;
  timeprecision 100ps;

  // Only written bytes are stored
  logic [7:0] mem [addr_t];

  // Unwritten bytes read back as a pattern of the full address
  function automatic logic [7:0] fill_byte(input addr_t a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] get_byte(input addr_t a);
    return mem.exists(a) ? mem[a] : fill_byte(a);
  endfunction

  // ==========================================================================
  // Single access in flight, all outputs move 1 ns after the edge
  // ==========================================================================
  initial begin
    int    delay;
    word_t rd;
    m_icb_cmd_ready = 1'b0;
    m_icb_rsp_valid = 1'b0;
    m_icb_rsp_rdata = '0;
    void'($urandom(80589));
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      if (m_icb_cmd_valid && m_icb_cmd_ready) begin
        rd = '0;
        for (int b = 0; b < BYTES_W; b++) begin
          if (m_icb_cmd_read) begin
            rd[8*b +: 8] = get_byte(m_icb_cmd_addr + addr_t'(b));
          end else if (m_icb_cmd_wmask[b]) begin
            mem[m_icb_cmd_addr + addr_t'(b)] = m_icb_cmd_wdata[8*b +: 8];
          end
        end
        // Extra response latency of 0 to 2 cycles
        delay = $urandom_range(2, 0);
        #1;
        m_icb_cmd_ready = 1'b0;
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        m_icb_rsp_valid = 1'b1;
        m_icb_rsp_rdata = rd;
        do begin
          @(posedge clk);
        end while (!m_icb_rsp_ready);
        #1;
        m_icb_rsp_valid = 1'b0;
        m_icb_cmd_ready = ($urandom_range(3, 0) != 0);
      end else begin
        #1;
        // Ready drops about one cycle in four
        m_icb_cmd_ready = ($urandom_range(3, 0) != 0);
      end
    end
  end

endmodule

/* tb_icb_unalign_bridge.sv */
/*
 * Testbench for the unaligned ICB bridge
 * Replays golden write and read records, checks responses and memory
 */
module tb_icb_unalign_bridge import ub_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          GOLD_DEPTH  = 512;
  localparam int          CYC_PER_REC = 200;
  localparam logic [31:0] END_OP      = 32'hf;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  sa_icb_cmd_valid;
  logic  sa_icb_cmd_ready;
  addr_t sa_icb_cmd_addr;
  logic  sa_icb_cmd_read;
  len_t  sa_icb_cmd_len;
  logic  sa_icb_w_valid;
  logic  sa_icb_w_ready;
  word_t sa_icb_cmd_wdata;
  mask_t sa_icb_cmd_wmask;
  logic  sa_icb_rsp_valid;
  logic  sa_icb_rsp_ready;
  word_t sa_icb_rsp_rdata;
  logic  m_icb_cmd_valid;
  logic  m_icb_cmd_ready;
  addr_t m_icb_cmd_addr;
  logic  m_icb_cmd_read;
  word_t m_icb_cmd_wdata;
  mask_t m_icb_cmd_wmask;
  logic  m_icb_rsp_valid;
  logic  m_icb_rsp_ready;
  word_t m_icb_rsp_rdata;

  // Golden records as a flat word stream
  logic [31:0] gold [0:GOLD_DEPTH-1];
  // Expected memory bytes
  logic [7:0]  model [addr_t];
  word_t       rsp_beats [$];
  int          n_rec;
  int          cycle_cnt   = 0;
  int          cycle_limit = 0;
  int          checks      = 0;
  int          data_errs   = 0;
  int          proto_errs  = 0;
  logic        rsp_hold_q  = 1'b0;
  word_t       rsp_data_q;

  always #4 clk = ~clk;

  icb_unalign_bridge UUT (.*);

  tb_word_mem u_mem (.*);

  // ==========================================================================
  // Golden parsing and byte model
  // ==========================================================================
  // Record: op addr len, then data and mask per write beat or data per read beat
  function automatic int count_records();
    int ptr = 0;
    int n = 0;
    while (ptr < GOLD_DEPTH - 2) begin
      if (gold[ptr] === END_OP) begin
        return n;
      end
      if (gold[ptr] !== 32'h0 && gold[ptr] !== 32'h1) begin
        return -1;
      end
      ptr = ptr + 3 + ((gold[ptr] == 32'h0) ? 2 : 1) * (int'(gold[ptr+2]) + 1);
      n++;
    end
    return -1;
  endfunction

  // Beat i byte b lands at addr + 4i + b
  function automatic void model_write(input addr_t a, input word_t d, input mask_t m);
    for (int b = 0; b < BYTES_W; b++) begin
      if (m[b]) begin
        model[a + addr_t'(b)] = d[8*b +: 8];
      end
    end
  endfunction

  // Returns 1 when every byte of the word is known to the model
  function automatic bit model_word(input addr_t a, output word_t w);
    bit known = 1'b1;
    w = '0;
    for (int b = 0; b < BYTES_W; b++) begin
      if (model.exists(a + addr_t'(b))) begin
        w[8*b +: 8] = model[a + addr_t'(b)];
      end else begin
        known = 1'b0;
      end
    end
    return known;
  endfunction

  // ==========================================================================
  // Upstream driving
  // ==========================================================================
  task automatic send_cmd(input addr_t addr, input logic read, input len_t len);
    sa_icb_cmd_valid = 1'b1;
    sa_icb_cmd_addr  = addr;
    sa_icb_cmd_read  = read;
    sa_icb_cmd_len   = len;
    do begin
      @(posedge clk);
    end while (!sa_icb_cmd_ready);
    #1;
    sa_icb_cmd_valid = 1'b0;
  endtask

  // Takes n beats with rsp_ready stalls, then watches for extra beats
  task automatic collect_rsp(input int n, input int rec);
    int stall;
    rsp_beats.delete();
    for (int k = 0; k < n; k++) begin
      stall = (3 * k + rec) % 5;
      sa_icb_rsp_ready = 1'b0;
      repeat (stall) begin
        @(posedge clk);
        #1;
      end
      sa_icb_rsp_ready = 1'b1;
      do begin
        @(posedge clk);
      end while (!sa_icb_rsp_valid);
      rsp_beats.push_back(sa_icb_rsp_rdata);
      #1;
    end
    // Nothing more may come before the bridge is idle again
    do begin
      @(posedge clk);
      if (sa_icb_rsp_valid) begin
        $display("Extra upstream response beat after %0d expected beats in record %0d",
                 n, rec);
        proto_errs++;
      end
    end while (!sa_icb_cmd_ready);
    #1;
  endtask

  task automatic run_write(input addr_t addr, input int len, input int base, input int rec);
    word_t data;
    mask_t mask;
    send_cmd(addr, 1'b0, len_t'(len));
    for (int i = 0; i <= len; i++) begin
      data             = gold[base + 2*i];
      mask             = mask_t'(gold[base + 2*i + 1]);
      sa_icb_w_valid   = 1'b1;
      sa_icb_cmd_wdata = data;
      sa_icb_cmd_wmask = mask;
      do begin
        @(posedge clk);
      end while (!sa_icb_w_ready);
      #1;
      model_write(addr + addr_t'(4*i), data, mask);
    end
    sa_icb_w_valid = 1'b0;
    // Exactly one write response with zero data
    collect_rsp(1, rec);
    checks++;
    if (rsp_beats[0] !== '0) begin
      $display("[ERROR] %0t: write response to 0x%08h carries data 0x%08h",
               $time, addr, rsp_beats[0]);
      data_errs++;
    end
  endtask

  task automatic run_read(input addr_t addr, input int len, input int base, input int rec);
    word_t exp_word;
    word_t mdl_word;
    send_cmd(addr, 1'b1, len_t'(len));
    collect_rsp(len + 1, rec);
    for (int i = 0; i <= len; i++) begin
      exp_word = gold[base + i];
      checks++;
      if (rsp_beats[i] !== exp_word) begin
        $display("[ERROR] %0t: read 0x%08h beat %0d got 0x%08h, golden 0x%08h",
                 $time, addr, i, rsp_beats[i], exp_word);
        data_errs++;
      end
      if (model_word(addr + addr_t'(4*i), mdl_word)) begin
        checks++;
        if (rsp_beats[i] !== mdl_word) begin
          $display("[ERROR] %0t: read 0x%08h beat %0d got 0x%08h, model 0x%08h",
                   $time, addr, i, rsp_beats[i], mdl_word);
          data_errs++;
        end
      end
    end
  endtask

  // Memory must hold every byte the model holds
  task automatic check_memory();
    foreach (model[a]) begin
      checks++;
      if (u_mem.mem[a] !== model[a]) begin
        $display("[ERROR] %0t: memory byte 0x%08h is 0x%02h, model 0x%02h",
                 $time, a, u_mem.mem[a], model[a]);
        data_errs++;
      end
    end
  endtask

  // ==========================================================================
  // Response hold check and cycle limit
  // ==========================================================================
  always @(posedge clk) begin
    if (rsp_hold_q && !(sa_icb_rsp_valid && sa_icb_rsp_rdata === rsp_data_q)) begin
      $display("[ERROR] %0t: upstream response dropped or changed while stalled", $time);
      data_errs++;
    end
    rsp_hold_q <= rst_n && sa_icb_rsp_valid && !sa_icb_rsp_ready;
    rsp_data_q <= sa_icb_rsp_rdata;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  // ==========================================================================
  // Main sequence
  // ==========================================================================
  initial begin
    int          ptr;
    logic [31:0] op;
    addr_t       addr;
    int          len;
    rst_n            = 1'b0;
    sa_icb_cmd_valid = 1'b0;
    sa_icb_cmd_addr  = '0;
    sa_icb_cmd_read  = 1'b0;
    sa_icb_cmd_len   = '0;
    sa_icb_w_valid   = 1'b0;
    sa_icb_cmd_wdata = '0;
    sa_icb_cmd_wmask = '0;
    sa_icb_rsp_ready = 1'b0;
    $readmemh("ub_golden.txt", gold);
    n_rec = count_records();
    if (n_rec < 1) begin
      $display("Golden file ub_golden.txt is missing or malformed");
      proto_errs++;
      // No records to replay
      n_rec = 0;
    end
    // Reset time plus a budget per record
    cycle_limit = CYC_PER_REC * n_rec + 16;
    repeat (8) @(posedge clk);
    if (sa_icb_cmd_ready || sa_icb_w_ready || sa_icb_rsp_valid || m_icb_cmd_valid) begin
      $display("Bridge outputs not all low during reset");
      proto_errs++;
    end
    #1;
    rst_n = 1'b1;
    ptr = 0;
    for (int r = 0; r < n_rec; r++) begin
      op   = gold[ptr];
      addr = gold[ptr + 1];
      len  = int'(gold[ptr + 2]);
      if (op == 32'h0) begin
        run_write(addr, len, ptr + 3, r);
        ptr = ptr + 3 + 2 * (len + 1);
      end else begin
        run_read(addr, len, ptr + 3, r);
        ptr = ptr + 3 + len + 1;
      end
    end
    check_memory();
    $display("Records: %0d, checks: %0d, data errors: %0d, protocol errors: %0d",
             n_rec, checks, data_errs, proto_errs);
    if (data_errs == 0 && proto_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* ub_golden.txt */
// Unaligned bridge golden records, hex. Write: 0 addr len {data mask} per beat
// Read: 1 addr len {expected data} per beat. A single f ends the list
// Aligned fill of 0x100..0x11f, byte at 0x100+k holds k
0 100 7 03020100 f 07060504 f 0b0a0908 f 0f0e0d0c f 13121110 f 17161514 f 1b1a1918 f 1f1e1d1c f
1 100 7 03020100 07060504 0b0a0908 0f0e0d0c 13121110 17161514 1b1a1918 1f1e1d1c
// Aligned single word, lanes 0 and 2 only
0 104 0 aabbccdd 5
1 104 0 07bb05dd
// Single beat at offsets 1, 2 and 3, read back over both words
0 109 0 44332211 f
1 108 1 33221108 0f0e0d44
0 112 0 88776655 f
1 110 1 66551110 17168877
0 11b 0 ccbbaa99 b
1 118 1 991a1918 1fcc1daa
// Unaligned reads over the patched area
1 10e 3 11100f0e 88776655 19181716 1daa991a
1 101 0 dd030201
// Two beat offset 1 write with partial masks
0 105 1 5a5a5a5a 6 12345678 9
1 104 2 5a5a05dd 33227808 0f0e0d12
// Eight beat burst at offset 3, then same and offset 2 read back
0 203 7 a0a1a2a3 f b0b1b2b3 f c0c1c2c3 f d0d1d2d3 f e0e1e2e3 f f0f1f2f3 f 01234567 f 89abcdef f
1 203 7 a0a1a2a3 b0b1b2b3 c0c1c2c3 d0d1d2d3 e0e1e2e3 f0f1f2f3 01234567 89abcdef
1 206 2 b1b2b3a0 c1c2c3b0 d1d2d3c0
f

/* icb_unalign_bridge.f */
ub_pkg.sv
ub_ctl_if.sv
ub_cmd_ctrl.sv
ub_wr_align.sv
ub_rd_merge.sv
icb_unalign_bridge.sv
tb_word_mem.sv
tb_icb_unalign_bridge.sv
